// ==== testbench/cpuStim.txt ====
# program word count (decimal), then the program words in hex
# expected output count (decimal), then the expected outPort values in hex, in program order
21
08800014 09007FFA B8800000 B9000000
19890000 22090000 2A890000 33090000
8B880000 94080000 5C900000 4D100000
B9800000 BA000000 BA800000 BB000000
BB800000 BC000000 BC800000 BD000000
D8000000
10
00000014 FFFFFFFA 0000000E 0000001A
00000010 FFFFFFFE FFFFFFEC FFFFFFEB
FFFFFFF4 7FFFFFFD

// ==== list.f ====
logic/cpuPkg.sv
logic/controlUnit.sv
logic/registerFile.sv
logic/alu.sv
logic/busUnit.sv
logic/cpuTop.sv
testbench/cpuTb_asserts.sv
testbench/cpuTb.sv

// ==== testbench/cpuTb.sv ====
`default_nettype none

module cpuTb import cpuPkg::*; ();

    logic                 Clock;
    logic                 arstN;
    logic [dataWidth-1:0] memData;
    logic                 memRead;
    logic [dataWidth-1:0] memAddr;
    logic                 outValid;
    logic [dataWidth-1:0] outPort;
    logic                 halted;

    logic [dataWidth-1:0] progWords [$];
    logic [dataWidth-1:0] expected [$];
    int progLen      = 0;
    int cycle        = 0;
    int readCount    = 0;
    int outCount     = 0;
    int lastOutRead  = 0;
    int lastOutCycle = 0;

    cpuTop cpuTop_inst (
        .Clock    (Clock),
        .arstN    (arstN),
        .memData  (memData),
        .memRead  (memRead),
        .memAddr  (memAddr),
        .outValid (outValid),
        .outPort  (outPort),
        .halted   (halted)
    );

    // instruction memory answers in the same cycle
    always_comb begin
        memData = (memAddr < progLen) ? progWords[memAddr] : '0;
    end

    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input logic [dataWidth-1:0] expectedValue,
                             input logic [dataWidth-1:0] actual);
        if (actual !== expectedValue) begin
            abortRun($sformatf("FAIL %s expected 0x%08h actual 0x%08h",
                               name, expectedValue, actual));
        end
    endtask

    task automatic checkFlag(input string name, input logic expectedValue, input logic actual);
        if (actual !== expectedValue) begin
            abortRun($sformatf("FAIL %s expected %b actual %b", name, expectedValue, actual));
        end
    endtask

    task automatic checkCount(input string name, input int expectedValue, input int actual);
        if (actual != expectedValue) begin
            abortRun($sformatf("FAIL %s expected %0d actual %0d", name, expectedValue, actual));
        end
    endtask

    task automatic readHex(input int fd, output logic [dataWidth-1:0] value);
        if ($fscanf(fd, "%h", value) != 1) begin
            abortRun("stimulus file ended before all values were read");
        end
    endtask

    // strobes and outPort are settled by the falling edge
    always @(negedge Clock) begin
        cycle++;
        if (memRead) begin
            checkWord($sformatf("fetch %0d address", readCount), readCount, memAddr);
            readCount++;
        end
        if (outValid) begin
            if (outCount >= expected.size()) begin
                abortRun("an output appeared beyond the expected count");
            end
            checkWord($sformatf("out %0d value", outCount), expected[outCount], outPort);
            if (outCount > 0 && lastOutRead == readCount - 1) begin
                checkCount($sformatf("out %0d spacing", outCount), 6, cycle - lastOutCycle);
            end
            lastOutRead  = readCount;  // index of the out instruction just seen
            lastOutCycle = cycle;
            outCount++;
        end
    end

    initial begin
        wait (progLen > 0);
        repeat (progLen * 6 + 40) @(posedge Clock);
        abortRun($sformatf("timed out after %0d cycles without reaching halt",
                           progLen * 6 + 40));
    end

    initial begin
        int                   fd;
        int                   count;
        string                header;
        logic [dataWidth-1:0] word;
        arstN = 1'b0;
        fd = $fopen("testbench/cpuStim.txt", "r");
        if (fd == 0) begin
            abortRun("could not open testbench/cpuStim.txt");
        end
        void'($fgets(header, fd));  // two column description lines
        void'($fgets(header, fd));
        if ($fscanf(fd, "%d", count) != 1) begin
            abortRun("program word count missing from stimulus file");
        end
        for (int i = 0; i < count; i++) begin
            readHex(fd, word);
            progWords.push_back(word);
        end
        if ($fscanf(fd, "%d", count) != 1) begin
            abortRun("expected output count missing from stimulus file");
        end
        for (int i = 0; i < count; i++) begin
            readHex(fd, word);
            expected.push_back(word);
        end
        $fclose(fd);
        if (progWords.size() == 0) begin
            abortRun("stimulus file holds no program words");
        end
        progLen = progWords.size();

        repeat (2) @(posedge Clock);
        arstN <= 1'b1;

        wait (halted === 1'b1);
        repeat (6) @(negedge Clock);  // any stray strobe would show here
        checkFlag("halted", 1'b1, halted);
        checkCount("output count", expected.size(), outCount);
        checkFlag("assertion failure", 1'b0, cpuTop_inst.cpuTb_asserts_inst.assertFailed);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/cpuTb_asserts.sv ====
`default_nettype none

module cpuTb_asserts (
    input wire logic Clock,
    input wire logic arstN,
    input wire logic memRead,
    input wire logic outValid,
    input wire logic halted
);

    logic haltSeen;
    logic assertFailed = 1'b0;  // read by the testbench at the end of the run

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            haltSeen <= 1'b0;
        end else if (halted) begin
            haltSeen <= 1'b1;
        end
    end

    singleCycleRead: assert property (@(posedge Clock) disable iff (!arstN)
        memRead |=> !memRead)
    else begin
        assertFailed = 1'b1;
        $error("memRead stayed high for two cycles in a row");
    end

    readOutExclusive: assert property (@(posedge Clock) disable iff (!arstN)
        !(memRead && outValid))
    else begin
        assertFailed = 1'b1;
        $error("memRead and outValid were high in the same cycle");
    end

    quietAfterHalt: assert property (@(posedge Clock) disable iff (!arstN)
        (halted || haltSeen) |-> (!memRead && !outValid))
    else begin
        assertFailed = 1'b1;
        $error("strobe seen after the processor halted");
    end

endmodule

bind cpuTop cpuTb_asserts cpuTb_asserts_inst (
    .Clock    (Clock),
    .arstN    (arstN),
    .memRead  (memRead),
    .outValid (outValid),
    .halted   (halted)
);

`default_nettype wire

// ==== logic/cpuTop.sv ====
`default_nettype none

module cpuTop import cpuPkg::*; (
    input  wire logic                 Clock,
    input  wire logic                 arstN,
    input  wire logic [dataWidth-1:0] memData,
    output logic                      memRead,
    output logic      [dataWidth-1:0] memAddr,
    output logic                      outValid,
    output logic      [dataWidth-1:0] outPort,
    output logic                      halted
);

    ctrlT                 ctrl;
    instrT                instr;
    logic [dataWidth-1:0] bus;
    logic [dataWidth-1:0] yValue;
    logic [dataWidth-1:0] zLow;

    controlUnit controlUnit_inst (
        .Clock    (Clock),
        .arstN    (arstN),
        .instr    (instr),
        .ctrl     (ctrl),
        .memRead  (memRead),
        .outValid (outValid),
        .halted   (halted)
    );

    // the register read value doubles as the output port
    registerFile registerFile_inst (
        .Clock   (Clock),
        .arstN   (arstN),
        .ctrl    (ctrl),
        .bus     (bus),
        .regData (outPort)
    );

    alu alu_inst (
        .Clock  (Clock),
        .arstN  (arstN),
        .ctrl   (ctrl),
        .yValue (yValue),
        .bus    (bus),
        .zLow   (zLow)
    );

    busUnit busUnit_inst (
        .Clock   (Clock),
        .arstN   (arstN),
        .ctrl    (ctrl),
        .memData (memData),
        .regData (outPort),
        .zLow    (zLow),
        .bus     (bus),
        .instr   (instr),
        .yValue  (yValue),
        .memAddr (memAddr)
    );

endmodule

`default_nettype wire

// ==== logic/busUnit.sv ====
`default_nettype none

module busUnit import cpuPkg::*; (
    input  wire logic                 Clock,
    input  wire logic                 arstN,
    input  wire ctrlT                 ctrl,
    input  wire logic [dataWidth-1:0] memData,
    input  wire logic [dataWidth-1:0] regData,
    input  wire logic [dataWidth-1:0] zLow,
    output logic      [dataWidth-1:0] bus,
    output instrT                     instr,
    output logic      [dataWidth-1:0] yValue,
    output logic      [dataWidth-1:0] memAddr
);

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] mar;
    logic [dataWidth-1:0] mdr;
    logic [dataWidth-1:0] y;
    instrT                ir;
    logic [dataWidth-1:0] constExt;

    assign constExt = {{(dataWidth-constWidth){ir.constant[constWidth-1]}}, ir.constant};

    always_comb begin
        case (ctrl.busSrc)
            busPc:    bus = pc;
            busMdr:   bus = mdr;
            busReg:   bus = regData;
            busZLow:  bus = zLow;
            busConst: bus = constExt;
            busNone:  bus = '0;
            default:  bus = '0;
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            pc  <= '0;
            mar <= '0;
            mdr <= '0;
            ir  <= '0;
            y   <= '0;
        end else begin
            if (ctrl.pcLoad) begin
                pc <= pc + 1'b1;  // word addressed
            end
            if (ctrl.marLoad) begin
                mar <= bus;
            end
            if (ctrl.mdrLoad) begin
                mdr <= memData;  // memory answers in the read cycle
            end
            if (ctrl.irLoad) begin
                ir <= bus;
            end
            if (ctrl.yLoad) begin
                y <= bus;
            end
        end
    end

    assign instr   = ir;
    assign yValue  = y;
    assign memAddr = mar;

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`default_nettype none

module alu import cpuPkg::*; (
    input  wire logic                 Clock,
    input  wire logic                 arstN,
    input  wire ctrlT                 ctrl,
    input  wire logic [dataWidth-1:0] yValue,
    input  wire logic [dataWidth-1:0] bus,
    output logic      [dataWidth-1:0] zLow
);

    logic [dataWidth-1:0] result;
    logic [dataWidth-1:0] zReg;

    // a = y, b = bus
    always_comb begin
        case (ctrl.aluOp)
            opAdd:   result = yValue + bus;
            opSub:   result = yValue - bus;
            opAnd:   result = yValue & bus;
            opOr:    result = yValue | bus;
            opNeg:   result = ~yValue + 1'b1;
            opNot:   result = ~yValue;
            opShl:   result = {yValue[dataWidth-2:0], 1'b0};
            opShr:   result = {1'b0, yValue[dataWidth-1:1]};
            opLdi:   result = bus;
            default: result = '0;
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            zReg <= '0;
        end else if (ctrl.zLoad) begin
            zReg <= result;
        end
    end

    assign zLow = zReg;

endmodule

`default_nettype wire

// ==== logic/registerFile.sv ====
`default_nettype none

module registerFile import cpuPkg::*; (
    input  wire logic                 Clock,
    input  wire logic                 arstN,
    input  wire ctrlT                 ctrl,
    input  wire logic [dataWidth-1:0] bus,
    output logic      [dataWidth-1:0] regData
);

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite) begin
            regs[ctrl.regSel] <= bus;
        end
    end

    // one select serves both the bus read and the write target
    assign regData = regs[ctrl.regSel];

endmodule

`default_nettype wire

// ==== logic/controlUnit.sv ====
`default_nettype none

module controlUnit import cpuPkg::*; (
    input  wire logic  Clock,
    input  wire logic  arstN,
    input  wire instrT instr,
    output ctrlT       ctrl,
    output logic       memRead,
    output logic       outValid,
    output logic       halted
);

    phaseT phase;
    phaseT nextPhase;
    logic  running;  // set on the first edge after reset

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            running <= 1'b0;
            phase   <= phaseT0;
        end else begin
            running <= 1'b1;
            if (running) begin
                phase <= nextPhase;
            end
        end
    end

    always_comb begin
        case (phase)
            phaseT0: nextPhase = phaseT1;
            phaseT1: nextPhase = phaseT2;
            phaseT2: nextPhase = phaseT3;
            phaseT3: nextPhase = (instr.opcode == opHalt) ? phaseHalt : phaseT4;
            phaseT4: nextPhase = phaseT5;
            phaseT5: nextPhase = phaseT0;
            default: nextPhase = phaseHalt;
        endcase
    end

    always_comb begin
        ctrl     = '0;
        memRead  = 1'b0;
        outValid = 1'b0;
        if (running) begin
            case (phase)
                phaseT0: begin
                    ctrl.busSrc  = busPc;
                    ctrl.marLoad = 1'b1;
                    ctrl.pcLoad  = 1'b1;
                end
                phaseT1: begin
                    memRead      = 1'b1;
                    ctrl.mdrLoad = 1'b1;
                end
                phaseT2: begin
                    ctrl.busSrc = busMdr;
                    ctrl.irLoad = 1'b1;
                end
                phaseT3: begin
                    if (instr.opcode != opHalt) begin
                        ctrl.busSrc = busReg;
                        ctrl.regSel = instr.rb;
                        ctrl.yLoad  = 1'b1;
                    end
                end
                phaseT4: begin
                    case (instr.opcode)
                        opAdd, opSub, opAnd, opOr, opNeg, opNot, opShl, opShr: begin
                            ctrl.busSrc = busReg;
                            ctrl.regSel = instr.rc;
                            ctrl.zLoad  = 1'b1;
                            ctrl.aluOp  = instr.opcode;
                        end
                        opLdi: begin
                            ctrl.busSrc = busConst;  // alu passes the constant through
                            ctrl.zLoad  = 1'b1;
                            ctrl.aluOp  = opLdi;
                        end
                        default: ;
                    endcase
                end
                phaseT5: begin
                    case (instr.opcode)
                        opAdd, opSub, opAnd, opOr, opNeg, opNot, opShl, opShr, opLdi: begin
                            ctrl.busSrc   = busZLow;
                            ctrl.regSel   = instr.ra;
                            ctrl.regWrite = 1'b1;
                        end
                        opOut: begin
                            ctrl.busSrc = busReg;
                            ctrl.regSel = instr.ra;  // regData drives outPort
                            outValid    = 1'b1;
                        end
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    assign halted = (phase == phaseHalt);

endmodule

`default_nettype wire

// ==== logic/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    localparam int dataWidth  = 32;
    localparam int regCount   = 16;
    localparam int constWidth = 15;

    // opcode field values, bits 31:27 of the instruction word
    typedef enum logic [4:0] {
        opLdi  = 5'd1,
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opShr  = 5'd9,
        opShl  = 5'd11,
        opNeg  = 5'd17,
        opNot  = 5'd18,
        opOut  = 5'd23,
        opHalt = 5'd27
    } opcodeT;

    typedef enum logic [2:0] {
        phaseT0   = 3'd0,   // pc to mar, pc + 1
        phaseT1   = 3'd1,   // memory read into mdr
        phaseT2   = 3'd2,   // mdr to ir
        phaseT3   = 3'd3,   // rb to y
        phaseT4   = 3'd4,   // alu result into z
        phaseT5   = 3'd5,   // writeback or output
        phaseHalt = 3'd6
    } phaseT;

    typedef enum logic [2:0] {
        busNone  = 3'd0,
        busPc    = 3'd1,
        busMdr   = 3'd2,
        busReg   = 3'd3,
        busZLow  = 3'd4,
        busConst = 3'd5
    } busSrcT;

    typedef struct packed {
        opcodeT                opcode;
        logic [3:0]            ra;
        logic [3:0]            rb;
        logic [3:0]            rc;
        logic [constWidth-1:0] constant;
    } instrT;

    typedef struct packed {
        busSrcT     busSrc;
        logic [3:0] regSel;
        logic       regWrite;
        logic       pcLoad;
        logic       marLoad;
        logic       mdrLoad;
        logic       irLoad;
        logic       yLoad;
        logic       zLoad;
        opcodeT     aluOp;
    } ctrlT;

endpackage

`default_nettype wire
